//--- sources.f
rtl/id_pkg.sv
rtl/instr_decoder.sv
rtl/main_control.sv
rtl/register_file.sv
rtl/branch_resolver.sv
rtl/step_timer.sv
rtl/stage_sequencer.sv
rtl/id_stage.sv
sim/id_stage_properties.sv
sim/id_stage_tb.sv

//--- Makefile
TOP := id_stage_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
    import id_pkg::*;

    localparam int     MAX_CYCLES = 2000;
    localparam instr_t NOP        = 32'h0000_0000;
    localparam wb_t    NO_WB      = '0;

    logic      i_clock;
    logic      i_soft_reset;
    instr_t    i_instruction;
    pc_t       i_pc_next;
    wb_t       i_wb;
    logic      i_run;
    logic      i_step;
    step_cnt_t i_step_cycles;
    idex_t     o_idex;
    branch_t   o_branch;
    logic      o_stage_enable;
    logic      o_halted;

    integer     seed = 58125;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;
    int         test_start_errors;
    int         cycle_count;
    int         enabled_cycles;
    word_t      shadow [32];
    idex_t      expected_idex;
    seq_state_t seq_state;
    int         step_left;

    id_stage id_stage_inst (
        .i_clock        (i_clock),
        .i_soft_reset   (i_soft_reset),
        .i_instruction  (i_instruction),
        .i_pc_next      (i_pc_next),
        .i_wb           (i_wb),
        .i_run          (i_run),
        .i_step         (i_step),
        .i_step_cycles  (i_step_cycles),
        .o_idex         (o_idex),
        .o_branch       (o_branch),
        .o_stage_enable (o_stage_enable),
        .o_halted       (o_halted)
    );

    bind id_stage id_stage_properties properties_inst (
        .i_clock        (i_clock),
        .i_soft_reset   (i_soft_reset),
        .i_state        (stage_sequencer_inst.state),
        .i_stage_enable (o_stage_enable),
        .i_idex         (o_idex)
    );

    always #20 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model.
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t model_read(input reg_addr_t addr, input wb_t wb);
        if (addr == 5'd0) return '0;
        if (wb.we && wb.addr == addr) return wb.data;
        return shadow[addr];
    endfunction

    function automatic ctrl_word_t model_ctrl(input instr_t ins);
        ctrl_word_t c;
        c = '0;
        case (ins[31:26])
            OPC_SPECIAL: begin
                case (ins[5:0])
                    FN_ADDU: c.reg_write = 1'b1;
                    FN_SUBU: begin
                        c.reg_write = 1'b1;
                        c.alu_ctrl  = ALU_SUB;
                    end
                    FN_AND: begin
                        c.reg_write = 1'b1;
                        c.alu_ctrl  = ALU_AND;
                    end
                    FN_OR: begin
                        c.reg_write = 1'b1;
                        c.alu_ctrl  = ALU_OR;
                    end
                    FN_XOR: begin
                        c.reg_write = 1'b1;
                        c.alu_ctrl  = ALU_XOR;
                    end
                    FN_SLT: begin
                        c.reg_write = 1'b1;
                        c.alu_ctrl  = ALU_SLT;
                    end
                    FN_JALR: begin
                        c.reg_write = 1'b1;
                        c.link      = 1'b1;
                    end
                    default: c = '0;
                endcase
            end
            OPC_ADDI: begin
                c.reg_write = 1'b1;
                c.alu_src   = 1'b1;
            end
            OPC_ANDI: begin
                c.reg_write = 1'b1;
                c.alu_src   = 1'b1;
                c.alu_ctrl  = ALU_AND;
            end
            OPC_ORI: begin
                c.reg_write = 1'b1;
                c.alu_src   = 1'b1;
                c.alu_ctrl  = ALU_OR;
            end
            OPC_LUI: begin
                c.reg_write = 1'b1;
                c.alu_src   = 1'b1;
                c.alu_ctrl  = ALU_LUI;
            end
            OPC_LW, OPC_LB: begin
                c.reg_write  = 1'b1;
                c.alu_src    = 1'b1;
                c.mem_read   = 1'b1;
                c.mem_to_reg = 1'b1;
                c.mem_size   = (ins[31:26] == OPC_LB) ? MEM_BYTE : MEM_WORD;
            end
            OPC_SW, OPC_SB: begin
                c.alu_src   = 1'b1;
                c.mem_write = 1'b1;
                c.mem_size  = (ins[31:26] == OPC_SB) ? MEM_BYTE : MEM_WORD;
            end
            OPC_JAL: begin
                c.reg_write = 1'b1;
                c.link      = 1'b1;
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic word_t model_imm(input instr_t ins);
        if (ins[31:26] == OPC_ANDI || ins[31:26] == OPC_ORI) return {16'h0000, ins[15:0]};
        if (ins[31:26] == OPC_LUI) return {ins[15:0], 16'h0000};
        return {{16{ins[15]}}, ins[15:0]};
    endfunction

    function automatic idex_t model_idex(input instr_t ins, input pc_t pc, input wb_t wb);
        idex_t e;
        e.data_a  = model_read(ins[25:21], wb);
        e.data_b  = model_read(ins[20:16], wb);
        e.imm_ext = model_imm(ins);
        e.rs      = ins[25:21];
        e.rt      = ins[20:16];
        if (ins[31:26] == OPC_SPECIAL) e.rd = ins[15:11];
        else if (ins[31:26] == OPC_JAL) e.rd = 5'd31;
        else e.rd = ins[20:16];
        e.pc_next = pc;
        e.ctrl    = model_ctrl(ins);
        e.halt    = (ins == HALT_WORD);
        return e;
    endfunction

    function automatic branch_t model_branch(input instr_t ins, input pc_t pc, input wb_t wb);
        branch_t    b;
        word_t      a;
        word_t      t;
        logic [5:0] opc;
        b   = '0;
        opc = ins[31:26];
        a   = model_read(ins[25:21], wb);
        t   = model_read(ins[20:16], wb);
        if (opc == OPC_BEQ || opc == OPC_BNE) begin
            b.taken  = (opc == OPC_BEQ) ? (a == t) : (a != t);
            b.target = pc + ins[10:0];
        end else if (opc == OPC_J || opc == OPC_JAL) begin
            b.taken  = 1'b1;
            b.target = ins[10:0];
        end else if (opc == OPC_SPECIAL && (ins[5:0] == FN_JR || ins[5:0] == FN_JALR)) begin
            b.taken  = 1'b1;
            b.target = a[10:0];
        end
        return b;
    endfunction

    // Sequencer state after the coming rising edge.
    task automatic advance_sequencer(input logic run, input logic step, input step_cnt_t n,
                                     input logic halt_seen);
        if (seq_state != S_HALTED && halt_seen) begin
            seq_state = S_HALTED;
        end else if (seq_state == S_IDLE && run) begin
            seq_state = S_RUN;
        end else if (seq_state == S_IDLE && step && n != '0) begin
            seq_state = S_STEP;
            step_left = int'(n);
        end else if (seq_state == S_STEP) begin
            step_left--;
            if (step_left == 0) begin
                seq_state = S_IDLE;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers.
    ////////////////////////////////////////////////////////////////////////////

    function automatic instr_t r_instr(input int rs, input int rt, input int rd,
                                       input logic [5:0] fn);
        return {OPC_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic instr_t i_instr(input logic [5:0] opc, input int rs, input int rt,
                                       input logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    // Any subset instruction except HALT, plus an unused opcode.
    task automatic random_instr(output instr_t ins);
        logic [31:0] r;
        int          kind;
        r    = $random(seed);
        kind = ($random(seed) & 32'h7fff_ffff) % 20;
        case (kind)
            0:  ins = {OPC_SPECIAL, r[25:6], FN_ADDU};
            1:  ins = {OPC_SPECIAL, r[25:6], FN_SUBU};
            2:  ins = {OPC_SPECIAL, r[25:6], FN_AND};
            3:  ins = {OPC_SPECIAL, r[25:6], FN_OR};
            4:  ins = {OPC_SPECIAL, r[25:6], FN_XOR};
            5:  ins = {OPC_SPECIAL, r[25:6], FN_SLT};
            6:  ins = {OPC_SPECIAL, r[25:6], FN_JR};
            7:  ins = {OPC_SPECIAL, r[25:6], FN_JALR};
            8:  ins = {OPC_ADDI, r[25:0]};
            9:  ins = {OPC_ANDI, r[25:0]};
            10: ins = {OPC_ORI, r[25:0]};
            11: ins = {OPC_LUI, r[25:0]};
            12: ins = {OPC_LW, r[25:0]};
            13: ins = {OPC_SW, r[25:0]};
            14: ins = {OPC_LB, r[25:0]};
            15: ins = {OPC_SB, r[25:0]};
            16: ins = {OPC_BEQ, r[25:0]};
            17: ins = {OPC_BNE, r[25:0]};
            18: ins = {(r[0] ? OPC_J : OPC_JAL), r[25:0]};
            default: ins = {6'h3E, r[25:0]};
        endcase
    endtask

    task automatic check(input string name, input logic [159:0] exp, input logic [159:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %0t ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // Called at a falling edge and returns at the next one.
    task automatic tick(input instr_t ins, input pc_t pc, input wb_t wb,
                        input logic run, input logic step, input step_cnt_t n);
        logic  en;
        logic  exp_en;
        logic  halt_seen;
        idex_t next_idex;
        en        = o_stage_enable;
        halt_seen = expected_idex.halt;
        exp_en    = (seq_state == S_RUN || seq_state == S_STEP) && !halt_seen;
        check("o_stage_enable", 160'(exp_en), 160'(en));
        i_instruction = ins;
        i_pc_next     = pc;
        i_wb          = wb;
        i_run         = run;
        i_step        = step;
        i_step_cycles = n;
        next_idex     = model_idex(ins, pc, wb);
        #1;
        check("o_branch", 160'(model_branch(ins, pc, wb)), 160'(o_branch));
        if (wb.we && wb.addr != 5'd0) begin
            shadow[wb.addr] = wb.data;
        end
        if (exp_en) begin
            expected_idex = next_idex;
        end
        if (en) begin
            enabled_cycles++;
        end
        advance_sequencer(run, step, n, halt_seen);
        @(negedge i_clock);
        check("o_idex", 160'(expected_idex), 160'(o_idex));
    endtask

    task automatic random_tick();
        instr_t ins;
        random_instr(ins);
        tick(ins, pc_t'($random(seed)), NO_WB, 1'b0, 1'b0, '0);
    endtask

    task automatic apply_reset();
        i_soft_reset  = 1'b0;
        i_instruction = NOP;
        i_pc_next     = '0;
        i_wb          = NO_WB;
        i_run         = 1'b0;
        i_step        = 1'b0;
        i_step_cycles = '0;
        repeat (8) @(negedge i_clock);
        i_soft_reset = 1'b1;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        expected_idex = '0;
        seq_state     = S_IDLE;
        step_left     = 0;
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        enabled_cycles    = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d mismatches", tests_run, name, errors - test_start_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests.
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        word_t     v;
        step_cnt_t n;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_count  = 0;
        i_clock      = 1'b0;
        apply_reset();

        begin_test();
        check("o_idex", '0, 160'(o_idex));
        check("o_branch.taken", 0, 160'(o_branch.taken));
        check("o_stage_enable", 0, 160'(o_stage_enable));
        check("o_halted", 0, 160'(o_halted));
        tick(NOP, '0, NO_WB, 1'b0, 1'b1, '0);
        repeat (3) tick(NOP, '0, NO_WB, 1'b0, 1'b0, '0);
        check("enabled cycles", 0, 160'(enabled_cycles));
        end_test("reset");

        begin_test();
        for (int r = 0; r < 32; r++) begin
            tick(NOP, '0, {1'b1, reg_addr_t'(r), word_t'($random(seed))}, 1'b0, 1'b0, '0);
        end
        tick(NOP, '0, NO_WB, 1'b1, 1'b0, '0);
        for (int r = 0; r < 32; r++) begin
            tick(r_instr(r, (r + 1) % 32, r, FN_ADDU), pc_t'(r), NO_WB, 1'b0, 1'b0, '0);
        end
        tick(r_instr(0, 0, 3, FN_ADDU), '0, NO_WB, 1'b0, 1'b0, '0);
        check("o_idex.data_a", 0, 160'(o_idex.data_a));
        v = $random(seed);
        tick(r_instr(5, 6, 1, FN_ADDU), 11'd7, {1'b1, 5'd5, v}, 1'b0, 1'b0, '0);
        check("o_idex.data_a", 160'(v), 160'(o_idex.data_a));
        end_test("register file");

        begin_test();
        repeat (200) random_tick();
        end_test("decode");

        begin_test();
        v = $random(seed);
        tick(NOP, '0, {1'b1, 5'd1, v}, 1'b0, 1'b0, '0);
        tick(NOP, '0, {1'b1, 5'd2, v}, 1'b0, 1'b0, '0);
        tick(NOP, '0, {1'b1, 5'd3, ~v}, 1'b0, 1'b0, '0);
        tick(i_instr(OPC_BEQ, 1, 2, 16'h0005), 11'd40, NO_WB, 1'b0, 1'b0, '0);
        tick(i_instr(OPC_BEQ, 1, 3, 16'hFFF0), 11'd40, NO_WB, 1'b0, 1'b0, '0);
        tick(i_instr(OPC_BNE, 1, 2, 16'h0009), 11'd90, NO_WB, 1'b0, 1'b0, '0);
        tick(i_instr(OPC_BNE, 1, 3, 16'hFFFE), 11'd90, NO_WB, 1'b0, 1'b0, '0);
        tick({OPC_J, 26'h123_4567}, 11'd5, NO_WB, 1'b0, 1'b0, '0);
        tick(r_instr(1, 0, 0, FN_JR), 11'd5, NO_WB, 1'b0, 1'b0, '0);
        tick(r_instr(1, 2, 4, FN_ADDU), 11'd5, NO_WB, 1'b0, 1'b0, '0);
        end_test("branch resolution");

        // Two steps in a row from idle.
        apply_reset();
        begin_test();
        for (int s = 0; s < 2; s++) begin
            enabled_cycles = 0;
            n = step_cnt_t'(($random(seed) & 32'h7fff_ffff) % 20 + 1);
            tick(NOP, '0, NO_WB, 1'b0, 1'b1, n);
            repeat (int'(n) + 4) random_tick();
            check("enabled cycles", 160'(n), 160'(enabled_cycles));
        end
        end_test("step mode");

        apply_reset();
        begin_test();
        tick(NOP, '0, NO_WB, 1'b1, 1'b0, '0);
        repeat (4) random_tick();
        tick(HALT_WORD, 11'd3, NO_WB, 1'b0, 1'b0, '0);
        check("o_idex.halt", 1, 160'(o_idex.halt));
        check("o_halted", 0, 160'(o_halted));
        check("o_stage_enable", 0, 160'(o_stage_enable));
        tick(NOP, '0, NO_WB, 1'b0, 1'b0, '0);
        check("o_halted", 1, 160'(o_halted));
        enabled_cycles = 0;
        v = $random(seed);
        tick(NOP, '0, NO_WB, 1'b1, 1'b0, '0);
        tick(NOP, '0, {1'b1, 5'd7, v}, 1'b0, 1'b1, 8'd5);
        tick(NOP, '0, {1'b1, 5'd8, v}, 1'b0, 1'b0, '0);
        repeat (6) random_tick();
        check("enabled cycles", 0, 160'(enabled_cycles));
        tick(i_instr(OPC_BEQ, 7, 8, 16'h0002), 11'd20, NO_WB, 1'b0, 1'b0, '0);
        check("o_branch.taken", 1, 160'(o_branch.taken));
        tick(i_instr(OPC_BEQ, 7, 0, 16'h0002), 11'd20, NO_WB, 1'b0, 1'b0, '0);
        check("o_branch.taken", 0, 160'(o_branch.taken));
        check("o_halted", 1, 160'(o_halted));
        end_test("halt");

        $display("Tests: %0d run, %0d failed; checks: %0d, mismatches: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sim/id_stage_properties.sv
`timescale 1ns/1ps

module id_stage_properties (
    input logic               i_clock,
    input logic               i_soft_reset,
    input id_pkg::seq_state_t i_state,
    input logic               i_stage_enable,
    input id_pkg::idex_t      i_idex
);
    import id_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing.
    ////////////////////////////////////////////////////////////////////////////

    property closed_when_idle_or_halted;
        @(posedge i_clock) disable iff (!i_soft_reset)
            (i_state == S_IDLE || i_state == S_HALTED) |-> !i_stage_enable;
    endproperty

    property halted_is_sticky;
        @(posedge i_clock) disable iff (!i_soft_reset)
            (i_state == S_HALTED) |=> (i_state == S_HALTED);
    endproperty

    // ID/EX register is frozen while the stage is closed.
    property idex_holds;
        @(posedge i_clock) disable iff (!i_soft_reset)
            !i_stage_enable |=> (i_idex == $past(i_idex));
    endproperty

    assert property (closed_when_idle_or_halted)
        else $error("Stage enable high in idle or halted state");

    assert property (halted_is_sticky)
        else $error("Sequencer left the halted state");

    assert property (idex_holds)
        else $error("ID/EX register changed while the stage was closed");

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic              i_clock,
    input  logic              i_soft_reset,
    input  id_pkg::instr_t    i_instruction,
    input  id_pkg::pc_t       i_pc_next,
    input  id_pkg::wb_t       i_wb,
    input  logic              i_run,
    input  logic              i_step,
    input  id_pkg::step_cnt_t i_step_cycles,
    output id_pkg::idex_t     o_idex,
    output id_pkg::branch_t   o_branch,
    output logic              o_stage_enable,
    output logic              o_halted
);
    import id_pkg::*;

    instr_fields_t fields;
    logic          halt;
    ctrl_word_t    ctrl;
    word_t         rs_data;
    word_t         rt_data;
    idex_t         idex_next;

    ////////////////////////////////////////////////////////////////////////////
    // Decode.
    ////////////////////////////////////////////////////////////////////////////

    instr_decoder instr_decoder_inst (
        .i_instruction (i_instruction),
        .o_fields      (fields),
        .o_halt        (halt)
    );

    main_control main_control_inst (
        .i_instruction (i_instruction),
        .o_ctrl        (ctrl)
    );

    register_file register_file_inst (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_rs_addr    (fields.rs),
        .i_rt_addr    (fields.rt),
        .i_wb         (i_wb),
        .o_rs_data    (rs_data),
        .o_rt_data    (rt_data)
    );

    // Branch decision goes straight back to fetch.
    branch_resolver branch_resolver_inst (
        .i_kind    (fields.kind),
        .i_index   (fields.index),
        .i_imm_ext (fields.imm_ext),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .i_pc_next (i_pc_next),
        .o_branch  (o_branch)
    );

    stage_sequencer stage_sequencer_inst (
        .i_clock        (i_clock),
        .i_soft_reset   (i_soft_reset),
        .i_run          (i_run),
        .i_step         (i_step),
        .i_step_cycles  (i_step_cycles),
        .i_halt_latched (o_idex.halt),
        .o_stage_enable (o_stage_enable),
        .o_halted       (o_halted)
    );

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX register.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        idex_next.data_a  = rs_data;
        idex_next.data_b  = rt_data;
        idex_next.imm_ext = fields.imm_ext;
        idex_next.rs      = fields.rs;
        idex_next.rt      = fields.rt;
        idex_next.rd      = fields.rd;
        idex_next.pc_next = i_pc_next;
        idex_next.ctrl    = ctrl;
        idex_next.halt    = halt;
    end

    // Holds while the stage is closed.
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_idex <= '0;
        end else if (o_stage_enable) begin
            o_idex <= idex_next;
        end
    end

endmodule

//--- rtl/stage_sequencer.sv
`timescale 1ns/1ps

module stage_sequencer (
    input  logic              i_clock,
    input  logic              i_soft_reset,
    input  logic              i_run,
    input  logic              i_step,
    input  id_pkg::step_cnt_t i_step_cycles,
    input  logic              i_halt_latched,
    output logic              o_stage_enable,
    output logic              o_halted
);
    import id_pkg::*;

    seq_state_t state;
    seq_state_t state_next;
    logic       step_accept;
    logic       timer_load;
    logic       timer_expired;

    // Zero-length steps are dropped here.
    assign step_accept = i_step && (i_step_cycles != '0);
    assign timer_load  = (state == S_IDLE) && step_accept && !i_run && !i_halt_latched;

    // A latched halt freezes the ID/EX register until the state catches up.
    assign o_stage_enable = (state == S_RUN || state == S_STEP) && !i_halt_latched;
    assign o_halted       = (state == S_HALTED);

    step_timer step_timer_inst (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_load       (timer_load),
        .i_cycles     (i_step_cycles),
        .i_count_en   (o_stage_enable && state == S_STEP),
        .o_expired    (timer_expired)
    );

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (i_halt_latched) begin
                    state_next = S_HALTED;
                end else if (i_run) begin
                    state_next = S_RUN;
                end else if (step_accept) begin
                    state_next = S_STEP;
                end
            end
            S_RUN: begin
                if (i_halt_latched) begin
                    state_next = S_HALTED;
                end
            end
            S_STEP: begin
                if (i_halt_latched) begin
                    state_next = S_HALTED;
                end else if (timer_expired) begin
                    state_next = S_IDLE;
                end
            end
            S_HALTED: state_next = S_HALTED;
            default:  state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- rtl/step_timer.sv
`timescale 1ns/1ps

module step_timer (
    input  logic              i_clock,
    input  logic              i_soft_reset,
    input  logic              i_load,
    input  id_pkg::step_cnt_t i_cycles,
    input  logic              i_count_en,
    output logic              o_expired
);
    import id_pkg::*;

    step_cnt_t count;

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            count <= '0;
        end else if (i_load) begin
            count <= i_cycles;
        end else if (i_count_en && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Last open cycle of the step.
    assign o_expired = i_count_en && (count == step_cnt_t'(1));

endmodule

//--- rtl/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
    input  id_pkg::branch_kind_t i_kind,
    input  logic [25:0]          i_index,
    input  id_pkg::word_t        i_imm_ext,
    input  id_pkg::word_t        i_rs_data,
    input  id_pkg::word_t        i_rt_data,
    input  id_pkg::pc_t          i_pc_next,
    output id_pkg::branch_t      o_branch
);
    import id_pkg::*;

    logic equal;
    pc_t  rel_target;

    assign equal      = (i_rs_data == i_rt_data);
    assign rel_target = i_pc_next + i_imm_ext[PC_W-1:0];

    always_comb begin
        o_branch = '0;
        case (i_kind)
            BR_EQ: begin
                o_branch.taken  = equal;
                o_branch.target = rel_target;
            end
            BR_NE: begin
                o_branch.taken  = !equal;
                o_branch.target = rel_target;
            end
            // Absolute word address from the instruction index.
            BR_JUMP: begin
                o_branch.taken  = 1'b1;
                o_branch.target = i_index[PC_W-1:0];
            end
            BR_REG: begin
                o_branch.taken  = 1'b1;
                o_branch.target = i_rs_data[PC_W-1:0];
            end
            default: o_branch = '0;
        endcase
    end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic              i_clock,
    input  logic              i_soft_reset,
    input  id_pkg::reg_addr_t i_rs_addr,
    input  id_pkg::reg_addr_t i_rt_addr,
    input  id_pkg::wb_t       i_wb,
    output id_pkg::word_t     o_rs_data,
    output id_pkg::word_t     o_rt_data
);
    import id_pkg::*;

    word_t regs [NUM_REGS];

    // Register 0 is never written.
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we && i_wb.addr != '0) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    // Read with bypass of the write in flight.
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (i_wb.we && addr == i_wb.addr) begin
            data = i_wb.data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        o_rs_data = read_port(i_rs_addr);
        o_rt_data = read_port(i_rt_addr);
    end

endmodule

//--- rtl/main_control.sv
`timescale 1ns/1ps

module main_control (
    input  id_pkg::instr_t     i_instruction,
    output id_pkg::ctrl_word_t o_ctrl
);
    import id_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = i_instruction[31:26];
    assign funct  = i_instruction[5:0];

    always_comb begin
        // Unknown codes, branches, J, JR and HALT leave this all zero.
        o_ctrl = '0;

        case (opcode)
            OPC_SPECIAL: begin
                o_ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: o_ctrl.alu_ctrl = ALU_ADD;
                    FN_SUBU: o_ctrl.alu_ctrl = ALU_SUB;
                    FN_AND:  o_ctrl.alu_ctrl = ALU_AND;
                    FN_OR:   o_ctrl.alu_ctrl = ALU_OR;
                    FN_XOR:  o_ctrl.alu_ctrl = ALU_XOR;
                    FN_SLT:  o_ctrl.alu_ctrl = ALU_SLT;
                    FN_JALR: o_ctrl.link     = 1'b1;
                    default: o_ctrl.reg_write = 1'b0;
                endcase
            end

            OPC_ADDI, OPC_ANDI, OPC_ORI, OPC_LUI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                case (opcode)
                    OPC_ANDI: o_ctrl.alu_ctrl = ALU_AND;
                    OPC_ORI:  o_ctrl.alu_ctrl = ALU_OR;
                    OPC_LUI:  o_ctrl.alu_ctrl = ALU_LUI;
                    default:  o_ctrl.alu_ctrl = ALU_ADD;
                endcase
            end

            OPC_LW, OPC_LB: begin
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.alu_src    = 1'b1;
                o_ctrl.alu_ctrl   = ALU_ADD;
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.mem_to_reg = 1'b1;
                o_ctrl.mem_size   = (opcode == OPC_LB) ? MEM_BYTE : MEM_WORD;
            end

            OPC_SW, OPC_SB: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_ctrl  = ALU_ADD;
                o_ctrl.mem_write = 1'b1;
                o_ctrl.mem_size  = (opcode == OPC_SB) ? MEM_BYTE : MEM_WORD;
            end

            OPC_JAL: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.link      = 1'b1;
            end

            default: o_ctrl = '0;
        endcase
    end

endmodule

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  id_pkg::instr_t        i_instruction,
    output id_pkg::instr_fields_t o_fields,
    output logic                  o_halt
);
    import id_pkg::*;

    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic [IMM_W-1:0] imm;

    assign opcode = i_instruction[31:26];
    assign funct  = i_instruction[5:0];
    assign imm    = i_instruction[15:0];

    assign o_halt = (i_instruction == HALT_WORD);

    always_comb begin
        o_fields.rs    = i_instruction[25:21];
        o_fields.rt    = i_instruction[20:16];
        o_fields.index = i_instruction[INDEX_W-1:0];

        // Sign extension unless the opcode says otherwise.
        case (opcode)
            OPC_ANDI, OPC_ORI: o_fields.imm_ext = {{(WORD_W - IMM_W){1'b0}}, imm};
            OPC_LUI:           o_fields.imm_ext = {imm, {(WORD_W - IMM_W){1'b0}}};
            default:           o_fields.imm_ext = {{(WORD_W - IMM_W){imm[IMM_W-1]}}, imm};
        endcase

        // Destination register.
        case (opcode)
            OPC_SPECIAL: o_fields.rd = i_instruction[15:11];
            OPC_JAL:     o_fields.rd = LINK_REG;
            default:     o_fields.rd = i_instruction[20:16];
        endcase

        o_fields.kind = BR_NONE;
        case (opcode)
            OPC_BEQ:        o_fields.kind = BR_EQ;
            OPC_BNE:        o_fields.kind = BR_NE;
            OPC_J, OPC_JAL: o_fields.kind = BR_JUMP;
            OPC_SPECIAL: begin
                if (funct == FN_JR || funct == FN_JALR) begin
                    o_fields.kind = BR_REG;
                end
            end
            default:        o_fields.kind = BR_NONE;
        endcase
    end

endmodule

//--- rtl/id_pkg.sv
package id_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths.
    ////////////////////////////////////////////////////////////////////////////

    localparam int INSTR_W     = 32;
    localparam int WORD_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int PC_W        = 11;
    localparam int STEP_CNT_W  = 8;
    localparam int IMM_W       = 16;
    localparam int INDEX_W     = 26;

    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [STEP_CNT_W-1:0] step_cnt_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
    } alu_ctrl_t;

    typedef enum logic {MEM_WORD, MEM_BYTE} mem_size_t;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_JUMP, BR_REG} branch_kind_t;

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_STEP, S_HALTED} seq_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles.
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      reg_write;
        logic      alu_src;
        alu_ctrl_t alu_ctrl;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        mem_size_t mem_size;
        logic      link;
    } ctrl_word_t;

    typedef struct packed {
        reg_addr_t          rs;
        reg_addr_t          rt;
        reg_addr_t          rd;
        word_t              imm_ext;
        logic [INDEX_W-1:0] index;
        branch_kind_t       kind;
    } instr_fields_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic taken;
        pc_t  target;
    } branch_t;

    typedef struct packed {
        word_t      data_a;
        word_t      data_b;
        word_t      imm_ext;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        pc_t        pc_next;
        ctrl_word_t ctrl;
        logic       halt;
    } idex_t;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings.
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_JAL     = 6'h03;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDI    = 6'h08;
    localparam logic [5:0] OPC_ANDI    = 6'h0C;
    localparam logic [5:0] OPC_ORI     = 6'h0D;
    localparam logic [5:0] OPC_LUI     = 6'h0F;
    localparam logic [5:0] OPC_LB      = 6'h20;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SB      = 6'h28;
    localparam logic [5:0] OPC_SW      = 6'h2B;

    localparam logic [5:0] FN_JR       = 6'h08;
    localparam logic [5:0] FN_JALR     = 6'h09;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_XOR      = 6'h26;
    localparam logic [5:0] FN_SLT      = 6'h2A;

    localparam instr_t    HALT_WORD    = 32'hFFFF_FFFF;
    localparam reg_addr_t LINK_REG     = 5'd31;

endpackage
